//--- collisionCheck.sv
// Frog against traffic overlap test
module collisionCheck (
    input  logic           Clk,
    input  logic           rst,
    input  logic           frameTick,
    input  frogPkg::coordT frogX,
    input  frogPkg::coordT frogY,
    input  frogPkg::coordT carXs [frogPkg::NUM_LANES],
    output logic           hit
);
    import frogPkg::*;

    logic overlap;

    // Interval overlap on X within the frog's own row
    always_comb
    begin
        overlap = 1'b0;
        for (int i = 0; i < NUM_LANES; i++)
        begin
            if (frogY == LANE_Y[i] &&
                carXs[i] < frogX + CELL &&                  // Car starts before frog ends
                frogX < carXs[i] + LANE_LEN[i])             // Frog starts before car ends
            begin
                overlap = 1'b1;
            end
        end
    end

    // Judged only at frame ticks, on positions before the move
    always_ff @(posedge Clk)
    begin
        if (rst)
            hit <= 1'b0;
        else
            hit <= frameTick && overlap;                    // One cycle pulse
    end

endmodule

//--- flist.f
frogPkg.sv
trafficLane.sv
frogMover.sv
collisionCheck.sv
gameControl.sv
frogCore.sv
frogCore_checker.sv
tb_frogCore.sv

//--- frogCore.sv
// Frog game playfield core
module frogCore (
    input  logic               Clk,
    input  logic               rst,
    input  logic               frameTick,
    input  frogPkg::keyCodeT   keycode,
    output frogPkg::coordT     frogX,
    output frogPkg::coordT     frogY,
    output frogPkg::livesT     lives,
    output frogPkg::gameStateT gameState
);
    import frogPkg::*;

    coordT carXs [NUM_LANES];
    logic  hit;
    logic  respawn;

    // --------------------------------------------------
    // Traffic, one car per lane
    // --------------------------------------------------
    for (genvar g = 0; g < NUM_LANES; g++) begin : gLane
        trafficLane #(
            .START_X   (LANE_START[g]),
            .SPEED     (LANE_SPEED[g]),
            .MOVE_LEFT (LANE_LEFT[g]),
            .LEN       (LANE_LEN[g])
        ) laneInst (
            .Clk       (Clk),
            .rst       (rst),
            .frameTick (frameTick),
            .carX      (carXs[g])
        );
    end

    // --------------------------------------------------
    // Frog, hit check and game control
    // --------------------------------------------------
    frogMover moverInst (
        .Clk       (Clk),
        .rst       (rst),
        .keycode   (keycode),
        .gameState (gameState),
        .respawn   (respawn),
        .frogX     (frogX),
        .frogY     (frogY)
    );

    collisionCheck collisionInst (
        .Clk       (Clk),
        .rst       (rst),
        .frameTick (frameTick),
        .frogX     (frogX),
        .frogY     (frogY),
        .carXs     (carXs),
        .hit       (hit)
    );

    gameControl controlInst (
        .Clk       (Clk),
        .rst       (rst),
        .keycode   (keycode),
        .hit       (hit),
        .frogY     (frogY),
        .gameState (gameState),
        .lives     (lives),
        .respawn   (respawn)                              // Returns frog to start
    );

endmodule

//--- frogCore_checker.sv
// Frog core port assertions
module frogCore_checker (
    input logic               Clk,
    input logic               rst,
    input frogPkg::coordT     frogX,
    input frogPkg::coordT     frogY,
    input frogPkg::livesT     lives,
    input frogPkg::gameStateT gameState
);
    timeunit 1ns;
    timeprecision 1ps;
    import frogPkg::*;

    // --------------------------------------------------
    // Range and state rules
    // --------------------------------------------------
    livesBound: assert property (@(posedge Clk) disable iff (rst) lives <= START_LIVES)
        else $error("lives above the start count");

    frogOnField: assert property (@(posedge Clk) disable iff (rst)
        frogX <= MAX_X && frogY <= MAX_Y)
        else $error("frog outside the field");

    gameOverEmpty: assert property (@(posedge Clk) disable iff (rst)
        gameState == ST_GAMEOVER |-> lives == 4'd0)
        else $error("game over with lives left");

    // Lose one life at a time or reload on a new game
    livesStep: assert property (@(posedge Clk) disable iff (rst)
        lives == $past(lives) || lives == $past(lives) - 4'd1 || lives == START_LIVES)
        else $error("lives changed by an illegal amount");

endmodule

bind frogCore frogCore_checker checkInst (
    .Clk       (Clk),
    .rst       (rst),
    .frogX     (frogX),
    .frogY     (frogY),
    .lives     (lives),
    .gameState (gameState)
);

//--- frogMover.sv
// Frog position from key presses
module frogMover (
    input  logic               Clk,
    input  logic               rst,
    input  frogPkg::keyCodeT   keycode,
    input  frogPkg::gameStateT gameState,
    input  logic               respawn,
    output frogPkg::coordT     frogX,
    output frogPkg::coordT     frogY
);
    import frogPkg::*;

    keyCodeT prevKey;
    logic    newPress;
    logic    canStep;

    // --------------------------------------------------
    // Key edge detect
    // --------------------------------------------------
    always_ff @(posedge Clk)
    begin
        if (rst)
            prevKey <= KEY_NONE;
        else
            prevKey <= keycode;
    end

    assign newPress = (keycode != prevKey);                 // Held key steps once
    assign canStep  = newPress && (gameState == ST_PLAY);

    // --------------------------------------------------
    // Position update
    // --------------------------------------------------
    always_ff @(posedge Clk)
    begin
        if (rst || respawn)                                 // Respawn beats a step
        begin
            frogX <= START_X;
            frogY <= START_Y;
        end
        else if (canStep)
        begin
            case (keycode)
                KEY_W:
                    frogY <= (frogY < CELL) ? 10'd0 : frogY - CELL;
                KEY_S:
                    frogY <= (frogY > MAX_Y - CELL) ? MAX_Y : frogY + CELL;
                KEY_A:
                    frogX <= (frogX < CELL) ? 10'd0 : frogX - CELL;
                KEY_D:
                    frogX <= (frogX > MAX_X - CELL) ? MAX_X : frogX + CELL;
                default:
                begin
                    frogX <= frogX;                         // Enter or no key
                    frogY <= frogY;
                end
            endcase
        end
    end

endmodule

//--- frogPkg.sv
// Frog game shared definitions
package frogPkg;

    // --------------------------------------------------
    // Basic types
    // --------------------------------------------------
    typedef logic [9:0] coordT;                  // Pixel coordinate
    typedef logic [3:0] livesT;                  // Life count

    typedef enum logic [1:0]
    {
        ST_START,
        ST_PLAY,
        ST_WIN,
        ST_GAMEOVER
    } gameStateT;

    // USB HID usage codes of the keys in play
    typedef enum logic [15:0]
    {
        KEY_NONE  = 16'h0000,
        KEY_W     = 16'h001A,
        KEY_A     = 16'h0004,
        KEY_S     = 16'h0016,
        KEY_D     = 16'h0007,
        KEY_ENTER = 16'h0028
    } keyCodeT;

    // --------------------------------------------------
    // Field geometry
    // --------------------------------------------------
    localparam coordT FIELD_WIDTH = 10'd640;
    localparam coordT CELL        = 10'd32;      // Frog size and step
    localparam coordT MAX_X       = 10'd608;
    localparam coordT MAX_Y       = 10'd448;
    localparam coordT START_X     = 10'd320;
    localparam coordT START_Y     = 10'd448;     // Bottom row
    localparam coordT GOAL_Y      = 10'd0;       // Top row wins
    localparam livesT START_LIVES = 4'd3;

    // --------------------------------------------------
    // Lane table, one car per lane
    // --------------------------------------------------
    localparam int NUM_LANES = 4;

    localparam coordT LANE_Y [NUM_LANES] =
        '{10'd384, 10'd352, 10'd320, 10'd288};   // Row of each lane

    localparam coordT LANE_START [NUM_LANES] =
        '{10'd100, 10'd400, 10'd200, 10'd500};

    localparam coordT LANE_SPEED [NUM_LANES] =
        '{10'd2, 10'd3, 10'd1, 10'd4};           // Pixels per frame

    localparam bit LANE_LEFT [NUM_LANES] =
        '{1'b0, 1'b1, 1'b0, 1'b1};               // 1 moves toward X 0

    // Third lane carries the truck
    localparam coordT LANE_LEN [NUM_LANES] =
        '{10'd32, 10'd32, 10'd64, 10'd32};

endpackage

//--- gameControl.sv
// Game state and life keeping
module gameControl (
    input  logic               Clk,
    input  logic               rst,
    input  frogPkg::keyCodeT   keycode,
    input  logic               hit,
    input  frogPkg::coordT     frogY,
    output frogPkg::gameStateT gameState,
    output frogPkg::livesT     lives,
    output logic               respawn
);
    import frogPkg::*;

    keyCodeT   prevKey;
    logic      enterPress;
    gameStateT nextState;
    livesT     nextLives;
    logic      nextRespawn;

    assign enterPress = (keycode == KEY_ENTER) && (prevKey != KEY_ENTER);

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------
    always_comb
    begin
        nextState   = gameState;
        nextLives   = lives;
        nextRespawn = 1'b0;
        case (gameState)
            ST_PLAY:
            begin
                if (hit)
                begin
                    if (lives <= 4'd1)                      // Last life gone
                    begin
                        nextLives = 4'd0;
                        nextState = ST_GAMEOVER;
                    end
                    else
                    begin
                        nextLives   = lives - 4'd1;
                        nextRespawn = 1'b1;                 // Back to start
                    end
                end
                else if (frogY == GOAL_Y && !respawn)       // Frog not yet sent home
                    nextState = ST_WIN;
            end
            default:                                        // Start, win, game over
            begin
                if (enterPress)
                begin
                    nextState   = ST_PLAY;
                    nextLives   = START_LIVES;
                    nextRespawn = 1'b1;
                end
            end
        endcase
    end

    // --------------------------------------------------
    // State registers
    // --------------------------------------------------
    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            prevKey   <= KEY_NONE;
            gameState <= ST_START;
            lives     <= START_LIVES;
            respawn   <= 1'b0;
        end
        else
        begin
            prevKey   <= keycode;
            gameState <= nextState;
            lives     <= nextLives;
            respawn   <= nextRespawn;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the frog core simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_frogCore -f flist.f -o simFrog
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simFrog > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "test failed" sim.log; then
    echo "Failure found in sim.log"
    exit 1
fi

echo "Simulation finished cleanly"
exit 0

//--- tb_frogCore.sv
// Frog core testbench
module tb_frogCore;
    timeunit 1ns;
    timeprecision 1ps;
    import frogPkg::*;

    localparam int     CLK_PERIOD   = 100;
    localparam int     FRAME_CYCLES = 64;
    // 4000 frames of 64 cycles plus margin make 30 ms
    localparam longint WATCHDOG_NS  = 64'd4000 * FRAME_CYCLES * CLK_PERIOD + 64'd4_400_000;

    logic      Clk = 1'b0;
    logic      rst;
    logic      frameTick = 1'b0;
    keyCodeT   keycode;
    coordT     frogX;
    coordT     frogY;
    livesT     lives;
    gameStateT gameState;

    logic      tickEnable = 1'b0;
    int        tickPhase = 0;
    int        sinceTick = 0;                        // Cycles since last frame tick
    integer    seed = 32'h5282_222a;
    coordT     expX;
    coordT     expY;
    livesT     expLives;
    gameStateT expState;

    frogCore u_dut (
        .Clk       (Clk),
        .rst       (rst),
        .frameTick (frameTick),
        .keycode   (keycode),
        .frogX     (frogX),
        .frogY     (frogY),
        .lives     (lives),
        .gameState (gameState)
    );

    initial
    begin
        forever #(CLK_PERIOD / 2) Clk = ~Clk;
    end

    // --------------------------------------------------
    // Frame ticks and tick age
    // --------------------------------------------------
    always @(negedge Clk)
    begin
        if (tickEnable && tickPhase == FRAME_CYCLES - 1)
        begin
            frameTick <= 1'b1;
            tickPhase <= 0;
        end
        else
        begin
            frameTick <= 1'b0;
            tickPhase <= tickEnable ? tickPhase + 1 : 0;
        end
    end

    always @(posedge Clk)
    begin
        sinceTick <= frameTick ? 1 : sinceTick + 1;   // 1 while hit is visible
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        abortRun();
    end

    // --------------------------------------------------
    // Failure and compare tasks
    // --------------------------------------------------
    task automatic abortRun();
        $display("test failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        abortRun();
    endtask

    task automatic checkCoord(input string name, input coordT got, input coordT exp);
        if (got !== exp)
        begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkLives(input string name, input livesT got, input livesT exp);
        if (got !== exp)
        begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkState(input string name, input gameStateT got, input gameStateT exp);
        if (got !== exp)
        begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abortRun();
        end
    endtask

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------
    task automatic tapKey(input keyCodeT key);
        @(negedge Clk);
        keycode = key;
        @(negedge Clk);                               // Result of the press is visible
        keycode = KEY_NONE;
    endtask

    // One press, then the frog against the step and clamp rules
    task automatic moveAndCheck(input keyCodeT key);
        tapKey(key);
        if (expState == ST_PLAY)
        begin
            case (key)
                KEY_W: expY = (expY < CELL) ? 10'd0 : expY - CELL;
                KEY_S: expY = (expY + CELL > MAX_Y) ? MAX_Y : expY + CELL;
                KEY_A: expX = (expX < CELL) ? 10'd0 : expX - CELL;
                KEY_D: expX = (expX + CELL > MAX_X) ? MAX_X : expX + CELL;
                default: ;
            endcase
        end
        checkCoord("frogX", frogX, expX);
        checkCoord("frogY", frogY, expY);
    endtask

    task automatic startGame();
        tapKey(KEY_ENTER);
        expState = ST_PLAY;
        expLives = START_LIVES;
        checkState("gameState", gameState, expState);
        checkLives("lives", lives, expLives);
        @(negedge Clk);                               // Respawn lands one cycle later
        expX = START_X;
        expY = START_Y;
        checkCoord("frogX", frogX, expX);
        checkCoord("frogY", frogY, expY);
        checkState("gameState", gameState, expState);
    endtask

    task automatic waitForLifeLoss(input int maxFrames);
        int cycles;
        cycles = 0;
        while (lives === expLives)
        begin
            @(negedge Clk);
            cycles++;
            if (cycles > maxFrames * FRAME_CYCLES)
                reportFailure("No life was lost within the frame limit");
        end
        if (sinceTick != 2)
            reportFailure("Lives changed at the wrong cycle after a frame tick");
        expLives = expLives - 4'd1;
        if (expLives == 0)
            expState = ST_GAMEOVER;
        checkLives("lives", lives, expLives);
        checkState("gameState", gameState, expState);
        @(negedge Clk);
        if (expState == ST_PLAY)
        begin
            expX = START_X;                           // Back at start three cycles after tick
            expY = START_Y;
        end
        checkCoord("frogX", frogX, expX);
        checkCoord("frogY", frogY, expY);
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic resetBehavior();
        expX = START_X;
        expY = START_Y;
        expLives = START_LIVES;
        expState = ST_START;
        checkState("gameState", gameState, expState);
        checkLives("lives", lives, expLives);
        checkCoord("frogX", frogX, expX);
        checkCoord("frogY", frogY, expY);
        moveAndCheck(KEY_W);                          // No movement before play
        moveAndCheck(KEY_A);
        moveAndCheck(KEY_S);
        moveAndCheck(KEY_D);
        checkState("gameState", gameState, expState);
    endtask

    task automatic frogMovement();
        int steps;
        startGame();
        steps = 8 + ($unsigned($random(seed)) % 8);  // Sometimes runs into the left edge
        repeat (steps) moveAndCheck(KEY_A);
        repeat (21) moveAndCheck(KEY_D);
        moveAndCheck(KEY_W);
        repeat (2) moveAndCheck(KEY_S);
        repeat (2) moveAndCheck(KEY_A);
        @(negedge Clk);
        keycode = KEY_D;
        repeat (6) @(negedge Clk);                    // Held key
        keycode = KEY_NONE;
        expX = expX + CELL;
        checkCoord("frogX", frogX, expX);
        while (expX > START_X)
            moveAndCheck(KEY_A);
    endtask

    task automatic hitAndRespawn();
        tickEnable <= 1'b1;
        moveAndCheck(KEY_W);
        moveAndCheck(KEY_W);
        waitForLifeLoss(330);
        moveAndCheck(KEY_W);                          // Row 416 has no traffic
        repeat (400 * FRAME_CYCLES) @(negedge Clk);
        checkLives("lives", lives, expLives);
        checkState("gameState", gameState, expState);
    endtask

    task automatic gameOverAndRestart();
        while (expLives > 0)
        begin
            while (expY > LANE_Y[0])
                moveAndCheck(KEY_W);
            waitForLifeLoss(330);
        end
        moveAndCheck(KEY_A);
        moveAndCheck(KEY_S);
        checkState("gameState", gameState, expState);
        tickEnable <= 1'b0;
        startGame();
    endtask

    task automatic reachGoal();
        repeat (14) moveAndCheck(KEY_W);
        @(negedge Clk);
        expState = ST_WIN;
        checkState("gameState", gameState, expState);
        checkLives("lives", lives, expLives);
        startGame();
    endtask

    initial
    begin
        rst = 1'b1;
        keycode = KEY_NONE;
        repeat (16) @(negedge Clk);
        rst = 1'b0;
        @(negedge Clk);
        $display("Test 1: reset");
        resetBehavior();
        $display("Test 2: movement");
        frogMovement();
        $display("Test 3: hit and respawn");
        hitAndRespawn();
        $display("Test 4: game over and restart");
        gameOverAndRestart();
        $display("Test 5: win");
        reachGoal();
        $display("test passed");
        $finish;
    end

endmodule

//--- trafficLane.sv
// Single traffic lane car
module trafficLane #(
    parameter int START_X   = 0,
    parameter int SPEED     = 1,
    parameter bit MOVE_LEFT = 1'b0,
    parameter int LEN       = 32
) (
    input  logic           Clk,
    input  logic           rst,
    input  logic           frameTick,
    output frogPkg::coordT carX
);
    import frogPkg::*;

    localparam logic [10:0] WIDTH = {1'b0, FIELD_WIDTH};
    // Leftward move is a rightward move by the complement
    localparam logic [10:0] DELTA = MOVE_LEFT ? WIDTH - 11'(SPEED) : 11'(SPEED);

    logic [10:0] sum;
    logic [10:0] nextX;

    // Car must start fully on the field
    if (START_X < 0 || START_X + LEN > FIELD_WIDTH || SPEED >= FIELD_WIDTH) begin : gBadLane
        $error("trafficLane: lane start, length or speed out of range");
    end

    assign sum   = {1'b0, carX} + DELTA;
    assign nextX = (sum >= WIDTH) ? sum - WIDTH : sum;    // Wrap at field edge

    always_ff @(posedge Clk)
    begin
        if (rst)
            carX <= coordT'(START_X);
        else if (frameTick)
            carX <= nextX[9:0];                           // One step per frame
    end

endmodule
